// ==== hw/axis_pkg.sv ====
/*
 * Shared definitions for the stream multiplexer.
 * Field widths of the AXI4-Stream sideband and the beat struct
 * that carries one transfer through every stage.
 */

package axis_pkg;

   // --------------------------------------------------
   // field widths
   // --------------------------------------------------

   // bytes of payload per beat.
   localparam int DATA_BYTES = 4;

   // stream id, carries the ingress port number in the testbench.
   localparam int TID_W = 4;

   // routing destination, passed through untouched.
   localparam int TDEST_W = 4;

   // user sideband, passed through untouched.
   localparam int TUSER_W = 8;

   // --------------------------------------------------
   // beat struct
   // --------------------------------------------------

   // one AXI4-Stream transfer, without valid and ready.
   // valid and ready travel next to it as separate bits.
   typedef struct packed {
      logic [DATA_BYTES-1:0][7:0] tdata;  // payload, byte 0 in the low lane.
      logic [DATA_BYTES-1:0]      tkeep;  // one bit per payload byte.
      logic                       tlast;  // marks the final beat of a packet.
      logic [TID_W-1:0]           tid;
      logic [TDEST_W-1:0]         tdest;
      logic [TUSER_W-1:0]         tuser;
   } axis_beat_t;

endpackage : axis_pkg

// ==== hw/arb_rr.sv ====
/*
 * Work-conserving round-robin arbiter.
 * Grants one requester at a time and keeps the grant locked
 * until the packet of the granted port ends with ack.
 */

module arb_rr #(
   parameter int N = 2
) (
   input  logic                 aclk,
   input  logic                 rst_n,
   input  logic [N-1:0]         req,
   input  logic [N-1:0]         ack,
   output logic [N-1:0]         grant,
   output logic [$clog2(N)-1:0] sel
);

   localparam int SEL_W = $clog2(N);

   // --------------------------------------------------
   // state
   // --------------------------------------------------

   // index of the port granted last, the search starts after it.
   logic [SEL_W-1:0] ptr;

   // result of the round-robin search.
   logic [SEL_W-1:0] pick;
   logic [N-1:0]     pick_onehot;
   logic             pick_found;

   // no grant is held.
   logic idle;

   // the granted port finishes its packet this cycle.
   logic done;

   assign idle = ~|grant;
   assign done = |(ack & grant);

   // --------------------------------------------------
   // round-robin search
   // --------------------------------------------------

   // walk from ptr+1 around to ptr and take the first request.
   // ports without req are skipped, so no cycle is wasted on them.
   always_comb begin
      int idx;
      pick        = ptr;
      pick_onehot = '0;
      pick_found  = 1'b0;
      for (int k = 1; k <= N; k++) begin
         idx = int'(ptr) + k;
         // wrap around past the last port.
         if (idx >= N) begin
            idx = idx - N;
         end
         if (!pick_found && req[idx]) begin
            pick             = SEL_W'(idx);
            pick_onehot[idx] = 1'b1;
            pick_found       = 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // grant register
   // --------------------------------------------------

   // idle -> grant one cycle after a request shows up.
   // granted -> hold until ack, then back to idle on the next edge.
   // the grant stays even if req drops in the middle of a packet.
   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         grant <= '0;
         sel   <= '0;
         // first search after reset begins at port 0.
         ptr   <= SEL_W'(N - 1);
      end else if (idle) begin
         if (pick_found) begin
            grant <= pick_onehot;
            sel   <= pick;
         end
      end else if (done) begin
         grant <= '0;
         // the finished port goes to the back of the line.
         ptr   <= sel;
      end
   end

   // --------------------------------------------------
   // assertions
   // --------------------------------------------------

   // at most one port owns the egress.
   a_grant_onehot0 : assert property (
      @(posedge aclk) disable iff (!rst_n)
      $onehot0(grant)
   );

   // the selected port cannot change inside a packet.
   a_sel_locked : assert property (
      @(posedge aclk) disable iff (!rst_n)
      (|grant && !done) |=> $stable(sel) && $stable(grant)
   );

   // an ack comes only from a port that holds the grant.
   // the top level gates each ready by its grant bit, which makes this hold.
   a_ack_granted : assert property (
      @(posedge aclk) disable iff (!rst_n)
      (ack & ~grant) == '0
   );

endmodule : arb_rr

// ==== hw/axis_tready_pipe.sv ====
/*
 * Ingress skid stage.
 * Registers the ready toward the sender and holds one beat
 * when the downstream side stalls.
 */

module axis_tready_pipe (
   input  logic                 aclk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  axis_pkg::axis_beat_t in_beat,
   output logic                 in_ready,
   output logic                 out_valid,
   output axis_pkg::axis_beat_t out_beat,
   input  logic                 out_ready
);

   import axis_pkg::*;

   // --------------------------------------------------
   // skid register
   // --------------------------------------------------

   logic       skid_valid;
   axis_beat_t skid_beat;

   // a beat enters while nobody downstream takes it.
   logic catch_beat;

   assign catch_beat = in_valid && in_ready && !out_ready && !skid_valid;

   // control state.
   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         skid_valid <= 1'b0;
         in_ready   <= 1'b1;
      end else if (catch_beat) begin
         // held beat, stop the sender from next cycle on.
         skid_valid <= 1'b1;
         in_ready   <= 1'b0;
      end else if (skid_valid && out_ready) begin
         // held beat drains, open up again.
         skid_valid <= 1'b0;
         in_ready   <= 1'b1;
      end
   end

   // payload only.
   always_ff @(posedge aclk) begin
      if (catch_beat) begin
         skid_beat <= in_beat;
      end
   end

   // --------------------------------------------------
   // output
   // --------------------------------------------------

   // pass-through while empty, the held beat goes first otherwise.
   assign out_valid = skid_valid || in_valid;
   assign out_beat  = skid_valid ? skid_beat : in_beat;

   // --------------------------------------------------
   // assertions
   // --------------------------------------------------

   // a stalled beat stays put, also across the move into the skid register.
   a_out_stable : assert property (
      @(posedge aclk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> out_valid && $stable(out_beat)
   );

endmodule : axis_tready_pipe

// ==== hw/axis_full_pipe.sv ====
/*
 * Egress register slice with a main and a spare entry.
 * Valid and ready are both registered, so no combinational
 * path crosses the slice.
 */

module axis_full_pipe (
   input  logic                 aclk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  axis_pkg::axis_beat_t in_beat,
   output logic                 in_ready,
   output logic                 out_valid,
   output axis_pkg::axis_beat_t out_beat,
   input  logic                 out_ready
);

   import axis_pkg::*;

   // --------------------------------------------------
   // entries
   // --------------------------------------------------

   // main entry feeds the egress directly.
   logic       main_valid;
   axis_beat_t main_beat;

   // spare entry catches a beat while main is held.
   logic       spare_valid;
   axis_beat_t spare_beat;

   logic in_xfer;
   logic main_free;

   assign in_xfer = in_valid && in_ready;

   // main can take a new beat when it is empty or drains now.
   assign main_free = !main_valid || out_ready;

   // control state.
   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         main_valid  <= 1'b0;
         spare_valid <= 1'b0;
         in_ready    <= 1'b1;
      end else if (main_free) begin
         // spare first to keep the order, else the new beat.
         // in_ready is low while spare is full, so both never meet.
         main_valid  <= spare_valid || in_xfer;
         spare_valid <= 1'b0;
         in_ready    <= 1'b1;
      end else if (in_xfer) begin
         // main is held, park the new beat.
         spare_valid <= 1'b1;
         in_ready    <= 1'b0;
      end
   end

   // payload only.
   always_ff @(posedge aclk) begin
      if (main_free) begin
         if (spare_valid) begin
            main_beat <= spare_beat;
         end else if (in_xfer) begin
            main_beat <= in_beat;
         end
      end
      if (!main_free && in_xfer) begin
         spare_beat <= in_beat;
      end
   end

   // --------------------------------------------------
   // output
   // --------------------------------------------------

   assign out_valid = main_valid;
   assign out_beat  = main_beat;

   // --------------------------------------------------
   // assertions
   // --------------------------------------------------

   // a stalled beat holds until the sink takes it.
   a_out_stable : assert property (
      @(posedge aclk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> out_valid && $stable(out_beat)
   );

endmodule : axis_full_pipe

// ==== hw/axis_mux.sv ====
/*
 * Packet multiplexer for AXI4-Stream.
 * Merges N ingress streams onto one egress by whole packets,
 * with a skid stage per ingress and a register slice at egress.
 */

module axis_mux #(
   parameter int N = 2
) (
   input  logic                 aclk,
   input  logic                 rst_n,
   input  logic [N-1:0]         in_valid,
   input  axis_pkg::axis_beat_t in_beat [N],
   output logic [N-1:0]         in_ready,
   output logic                 out_valid,
   output axis_pkg::axis_beat_t out_beat,
   input  logic                 out_ready
);

   import axis_pkg::*;

   localparam int SEL_W = $clog2(N);

   // --------------------------------------------------
   // internal streams
   // --------------------------------------------------

   // outputs of the ingress skid stages.
   logic [N-1:0] int_valid;
   axis_beat_t   int_beat [N];
   logic [N-1:0] int_ready;

   // arbiter handshake.
   logic [N-1:0]     req;
   logic [N-1:0]     ack;
   logic [N-1:0]     grant;
   logic [SEL_W-1:0] sel;

   // merged stream into the egress slice.
   logic       mux_valid;
   axis_beat_t mux_beat;
   logic       mux_ready;

   for (genvar i = 0; i < N; i++) begin : g_in
      // skid stage per ingress port.
      axis_tready_pipe in_pipe_inst (
         .aclk      (aclk),
         .rst_n     (rst_n),
         .in_valid  (in_valid[i]),
         .in_beat   (in_beat[i]),
         .in_ready  (in_ready[i]),
         .out_valid (int_valid[i]),
         .out_beat  (int_beat[i]),
         .out_ready (int_ready[i])
      );

      // any waiting beat is a request.
      assign req[i] = int_valid[i];

      // packet ends when its last beat transfers.
      assign ack[i] = int_valid[i] && int_beat[i].tlast && int_ready[i];

      // only the granted port sees the egress ready.
      assign int_ready[i] = grant[i] && mux_ready;
   end

   // --------------------------------------------------
   // arbitration
   // --------------------------------------------------

   arb_rr #(
      .N (N)
   ) arb_rr_inst (
      .aclk  (aclk),
      .rst_n (rst_n),
      .req   (req),
      .ack   (ack),
      .grant (grant),
      .sel   (sel)
   );

   // --------------------------------------------------
   // merge
   // --------------------------------------------------

   // valid is gated by the grant, so nothing leaks out while idle.
   assign mux_valid = |(int_valid & grant);
   assign mux_beat  = int_beat[sel];

   axis_full_pipe out_pipe_inst (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .in_valid  (mux_valid),
      .in_beat   (mux_beat),
      .in_ready  (mux_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat),
      .out_ready (out_ready)
   );

   // --------------------------------------------------
   // packet tracking for the assertion
   // --------------------------------------------------

   // open while a packet has started and its tlast is still due.
   logic             pkt_open;
   logic [SEL_W-1:0] pkt_sel;
   logic             mux_xfer;

   assign mux_xfer = mux_valid && mux_ready;

   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         pkt_open <= 1'b0;
         pkt_sel  <= '0;
      end else if (mux_xfer) begin
         pkt_open <= !mux_beat.tlast;
         pkt_sel  <= sel;
      end
   end

   // beats of one packet all come from the same port.
   a_no_interleave : assert property (
      @(posedge aclk) disable iff (!rst_n)
      (mux_xfer && pkt_open) |-> (sel == pkt_sel)
   );

endmodule : axis_mux

// ==== tests/tb_axis_mux.sv ====
/*
 * Testbench for the stream multiplexer.
 * Clock, reset, per-port drivers, scoreboard with compare tasks
 * and a watchdog. Tests and expected beats come from a data file.
 */

module tb_axis_mux;

   timeunit 1ns;
   timeprecision 100ps;

   import axis_pkg::*;

   localparam int NP    = 3;
   localparam int MAX_T = 16;
   localparam int MAX_B = 256;

   // --------------------------------------------------
   // DUT, clock and test state
   // --------------------------------------------------

   logic          aclk = 1'b0;
   logic          rst_n;
   logic [NP-1:0] in_valid;
   axis_beat_t    in_beat [NP];
   logic [NP-1:0] in_ready;
   logic          out_valid;
   axis_beat_t    out_beat;
   logic          out_ready;

   // 8 ns period.
   always #4 aclk = ~aclk;

   axis_mux #(
      .N (NP)
   ) axis_mux_inst (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat),
      .out_ready (out_ready)
   );

   // tests as read from the stimulus file.
   string         t_name  [MAX_T];
   logic [NP-1:0] t_mask  [MAX_T];
   bit            t_gaps  [MAX_T];
   int            t_pct   [MAX_T];
   string         t_order [MAX_T];
   axis_beat_t    b_beat  [MAX_B];
   int            b_port  [MAX_B];
   int            b_test  [MAX_B];
   int            n_tests = 0;
   int            total_beats = 0;
   bit            stim_loaded = 1'b0;

   // drive and scoreboard queues, one per port.
   axis_beat_t       drv_q [NP][$];
   axis_beat_t       exp_q [NP][$];
   logic [TID_W-1:0] exp_src [$];
   int               src_idx = 0;
   logic [NP-1:0]    cur_mask = '0;
   bit               cur_gaps = 1'b0;
   int               cur_pct = 100;
   bit               in_pkt = 1'b0;
   logic [TID_W-1:0] pkt_tid = '0;
   int               err_count = 0;
   int               n_pass = 0;
   int               n_fail = 0;
   int               cyc = 0;
   int               last_xfer = -1;
   logic [31:0]      rng_state;

   // xorshift32, drives gaps and the out_ready pattern.
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------

   task automatic check_beat(input axis_beat_t exp, input axis_beat_t act);
      if (act !== exp) begin
         $display("MISMATCH %0d ns: out_beat expected %h, got %h", $time, exp, act);
         err_count++;
      end
   endtask

   task automatic check_source(input string what, input logic [TID_W-1:0] exp,
                               input logic [TID_W-1:0] act);
      if (act !== exp) begin
         $display("MISMATCH %0d ns: %s expected %0d, got %0d", $time, what, exp, act);
         err_count++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH %0d ns: %s expected %b, got %b", $time, what, exp, act);
         err_count++;
      end
   endtask

   // --------------------------------------------------
   // stimulus file
   // --------------------------------------------------

   task automatic read_stimulus();
      int          fd;
      int          n;
      int          port;
      int          mask;
      int          gaps;
      int          pct;
      int          keep;
      int          last;
      int          dest;
      int          user;
      logic [31:0] data;
      axis_beat_t  beat;
      string       line;
      string       tag;
      string       name;
      string       order;
      fd = $fopen("tests/axis_mux_stimulus.txt", "r");
      if (fd == 0) begin
         $display("error: the stimulus file tests/axis_mux_stimulus.txt cannot be opened");
         err_count++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         tag = "";
         n = $sscanf(line, "%s", tag);
         if (tag == "t" && n_tests < MAX_T) begin
            n = $sscanf(line, "t %s %h %d %d %s", name, mask, gaps, pct, order);
            if (n != 5) begin
               $display("error: a test line of the stimulus file is incomplete: %s", line);
               err_count++;
            end
            t_name[n_tests]  = name;
            t_mask[n_tests]  = NP'(mask);
            t_gaps[n_tests]  = (gaps != 0);
            t_pct[n_tests]   = pct;
            t_order[n_tests] = order;
            n_tests++;
         end else if (tag == "b" && n_tests > 0 && total_beats < MAX_B) begin
            n = $sscanf(line, "b %d %h %h %d %h %h", port, data, keep, last, dest, user);
            if (n != 6) begin
               $display("error: a beat line of the stimulus file is incomplete: %s", line);
               err_count++;
            end
            // tid carries the port number.
            beat.tdata = data;
            beat.tkeep = DATA_BYTES'(keep);
            beat.tlast = (last != 0);
            beat.tid   = TID_W'(port);
            beat.tdest = TDEST_W'(dest);
            beat.tuser = TUSER_W'(user);
            b_beat[total_beats] = beat;
            b_port[total_beats] = port;
            b_test[total_beats] = n_tests - 1;
            total_beats++;
         end
      end
      $fclose(fd);
   endtask

   // --------------------------------------------------
   // drivers and monitor
   // --------------------------------------------------

   // a port keeps its beat until it transfers, then offers the next one.
   always @(posedge aclk) begin
      bit taken;
      if (!rst_n) begin
         in_valid  <= '0;
         out_ready <= 1'b0;
      end else begin
         out_ready <= (next_rand() % 32'd100) < 32'(cur_pct);
         for (int p = 0; p < NP; p++) begin
            taken = in_valid[p] && in_ready[p];
            if (taken) begin
               void'(drv_q[p].pop_front());
            end
            if (!in_valid[p] || taken) begin
               if (cur_mask[p] && drv_q[p].size() != 0 &&
                   (!cur_gaps || (next_rand() % 32'd100) < 32'd60)) begin
                  in_valid[p] <= 1'b1;
                  in_beat[p]  <= drv_q[p][0];
               end else begin
                  in_valid[p] <= 1'b0;
               end
            end
         end
      end
   end

   // scoreboard, keyed by the tid of each egress beat.
   always @(posedge aclk) begin
      int p;
      cyc++;
      if (rst_n && out_valid && out_ready) begin
         p = int'(out_beat.tid);
         // steady ready and no gaps leave at most one idle cycle between packets.
         if (!cur_gaps && cur_pct == 100 && last_xfer >= 0 &&
             cyc - last_xfer > 2) begin
            $display("error at %0d ns: egress stalled for %0d cycles between beats",
                     $time, cyc - last_xfer - 1);
            err_count++;
         end
         last_xfer = cyc;
         if (in_pkt) begin
            check_source("tid inside packet", pkt_tid, out_beat.tid);
         end else begin
            pkt_tid = out_beat.tid;
         end
         if (p >= NP || exp_q[p].size() == 0) begin
            $display("error at %0d ns: beat with tid %0d was never sent", $time, p);
            err_count++;
         end else begin
            check_beat(exp_q[p].pop_front(), out_beat);
         end
         in_pkt = !out_beat.tlast;
         if (out_beat.tlast) begin
            if (src_idx < exp_src.size()) begin
               check_source("packet source", exp_src[src_idx], pkt_tid);
            end
            src_idx++;
         end
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   task automatic report_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         n_pass++;
         $display("test %-14s ok", name);
      end else begin
         n_fail++;
         $display("test %-14s failed with %0d errors", name, err_count - errs_before);
      end
   endtask

   task automatic check_idle();
      check_bit("out_valid", 1'b0, out_valid);
      for (int p = 0; p < NP; p++) begin
         check_bit($sformatf("in_ready[%0d]", p), 1'b1, in_ready[p]);
      end
   endtask

   // three checks inside reset, release on the fourth edge, two after.
   task automatic check_reset();
      int errs;
      errs = err_count;
      repeat (3) begin
         @(negedge aclk);
         check_idle();
      end
      @(posedge aclk);
      rst_n <= 1'b1;
      repeat (2) begin
         @(negedge aclk);
         check_idle();
      end
      report_test("reset_state", errs);
   endtask

   function automatic bit busy();
      bit b;
      b = in_pkt;
      for (int p = 0; p < NP; p++) begin
         b = b || drv_q[p].size() != 0 || exp_q[p].size() != 0;
      end
      return b;
   endfunction

   // load at the falling edge, then wait until every beat came out.
   task automatic run_test(input int t);
      int  errs;
      byte c;
      errs = err_count;
      @(negedge aclk);
      for (int k = 0; k < total_beats; k++) begin
         if (b_test[k] == t) begin
            drv_q[b_port[k]].push_back(b_beat[k]);
            exp_q[b_port[k]].push_back(b_beat[k]);
         end
      end
      exp_src.delete();
      src_idx   = 0;
      last_xfer = -1;
      for (int k = 0; k < t_order[t].len(); k++) begin
         c = t_order[t][k];
         if (c >= "0" && c <= "9") begin
            exp_src.push_back(TID_W'(c - 8'h30));
         end
      end
      cur_mask = t_mask[t];
      cur_gaps = t_gaps[t];
      cur_pct  = t_pct[t];
      while (busy()) begin
         @(negedge aclk);
      end
      if (exp_src.size() != 0 && src_idx != exp_src.size()) begin
         $display("error: %0d packets came out, %0d were expected", src_idx, exp_src.size());
         err_count++;
      end
      report_test(t_name[t], errs);
   endtask

   initial begin
      rst_n     <= 1'b0;
      in_valid  <= '0;
      out_ready <= 1'b0;
      for (int p = 0; p < NP; p++) begin
         in_beat[p] <= '0;
      end
      rng_state = 32'd34330;
      read_stimulus();
      stim_loaded = 1'b1;
      check_reset();
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
      if (n_fail == 0 && err_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // limit is 20 cycles for every beat in the file.
   initial begin
      wait (stim_loaded);
      #(total_beats * 20 * 8);
      $display("timeout: the tests did not finish within %0d ns", total_beats * 20 * 8);
      $display("=== FAIL ===");
      $finish;
   end

endmodule : tb_axis_mux

// ==== tests/axis_mux_stimulus.txt ====
# t <name> <active port mask, hex> <ingress gaps 0/1> <out_ready duty %> <expected sources or ->
# b <port> <tdata hex> <tkeep hex> <tlast> <tdest hex> <tuser hex>   (tid is the port)
t integrity 7 0 100 012
b 0 a0a0a001 f 0 1 10
b 0 a0a0a002 3 1 1 11
b 1 b1b1b101 f 0 2 20
b 1 b1b1b102 1 1 2 21
b 2 c2c2c201 7 1 3 30
t rr_order 7 0 100 012012
b 0 00000010 f 1 0 01
b 0 00000011 f 1 0 02
b 1 00000020 f 1 5 03
b 1 00000021 f 1 5 04
b 2 00000030 f 1 a 05
b 2 00000031 f 1 a 06
t work_conserve 5 0 100 0202
b 0 0badf001 f 1 4 41
b 0 0badf002 f 1 4 42
b 2 0badf201 f 1 6 61
b 2 0badf202 f 1 6 62
t no_interleave 3 1 100 -
b 0 12340001 f 0 7 70
b 0 12340002 f 0 7 71
b 0 12340003 3 1 7 72
b 1 56780001 f 1 8 80
t back_pressure 7 1 40 -
b 0 deadbe01 f 0 9 90
b 0 deadbe02 f 1 9 91
b 1 feedca01 1 1 c c1
b 2 55aa5501 f 1 d d1

// ==== list.f ====
hw/axis_pkg.sv
hw/arb_rr.sv
hw/axis_tready_pipe.sv
hw/axis_full_pipe.sv
hw/axis_mux.sv
tests/tb_axis_mux.sv

// ==== Makefile ====
# Verilator build and run of the stream multiplexer testbench.

VERILATOR ?= verilator
TOP       ?= tb_axis_mux
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
